// ==== hdl/rvPkg.sv ====
package rvPkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int WORD_W = 32;
  localparam int REG_AW = 5;

  typedef logic [WORD_W-1:0] word_t;     // data or address word.
  typedef logic [REG_AW-1:0] regAddr_t;  // register index.
  typedef logic [6:0]        opcode_t;
  typedef logic [2:0]        aluOp_t;

  // ------------------------------------------------------------
  // major opcodes, RV32I encodings
  // ------------------------------------------------------------
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_OP     = 7'b0110011;
  localparam opcode_t OP_OPIMM  = 7'b0010011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;

  // funct fields of the supported instructions.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // bit 2 selects subtract, bits 1:0 pick the result.
  localparam aluOp_t ALU_AND = 3'b000;
  localparam aluOp_t ALU_OR  = 3'b001;
  localparam aluOp_t ALU_ADD = 3'b010;
  localparam aluOp_t ALU_SUB = 3'b110;
  localparam aluOp_t ALU_SLT = 3'b111;

endpackage

// ==== hdl/aluUnit.sv ====
module aluUnit import rvPkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  word_t sum;
  word_t diff;
  logic  lessThan;

  assign sum  = a + b;
  assign diff = a - b;

  // with differing signs a is the smaller one exactly when a is negative.
  always_comb begin
    if (a[WORD_W-1] != b[WORD_W-1]) begin
      lessThan = a[WORD_W-1];
    end else begin
      lessThan = diff[WORD_W-1];
    end
  end

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_SLT: result = {{(WORD_W-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);  // beq tests this after a subtract.

endmodule

// ==== hdl/regFile.sv ====
module regFile import rvPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  regAddr_t rs1,
  input  regAddr_t rs2,
  input  regAddr_t rd,
  input  logic     wrEn,
  input  word_t    wrData,
  output word_t    rdData1,
  output word_t    rdData2
);

  word_t regs [1:31];  // x0 has no storage.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && rd != '0) begin
      regs[rd] <= wrData;
    end
  end

  assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/instrDecoder.sv ====
module instrDecoder import rvPkg::*; (
  input  word_t    instr,
  output regAddr_t rs1,
  output regAddr_t rs2,
  output regAddr_t rd,
  output word_t    imm,
  output aluOp_t   aluOp,
  output logic     aluSrcImm,
  output logic     isLoad,
  output logic     isStore,
  output logic     isBranch,
  output logic     isJump,
  output logic     regWrite
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      immI;
  word_t      immS;
  word_t      immB;
  word_t      immJ;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // ------------------------------------------------------------
  // immediates, all sign extended from bit 31
  // ------------------------------------------------------------
  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm       = '0;
    aluOp     = ALU_AND;
    aluSrcImm = 1'b0;
    isLoad    = 1'b0;
    isStore   = 1'b0;
    isBranch  = 1'b0;
    isJump    = 1'b0;
    regWrite  = 1'b0;
    case (opcode)
      OP_LOAD: if (funct3 == F3_WORD) begin
        imm = immI;
        aluOp = ALU_ADD;
        aluSrcImm = 1'b1;
        isLoad = 1'b1;
        regWrite = 1'b1;
      end
      OP_STORE: if (funct3 == F3_WORD) begin
        imm = immS;
        aluOp = ALU_ADD;
        aluSrcImm = 1'b1;
        isStore = 1'b1;
      end
      OP_OPIMM: if (funct3 == F3_ADD_SUB) begin  // addi only.
        imm = immI;
        aluOp = ALU_ADD;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
      end
      OP_OP: begin
        regWrite = 1'b1;
        case (funct3)
          F3_ADD_SUB: aluOp = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLT:     aluOp = ALU_SLT;
          F3_OR:      aluOp = ALU_OR;
          F3_AND:     aluOp = ALU_AND;
          default:    regWrite = 1'b0;
        endcase
        // only sub may carry a nonzero funct7.
        if (funct7 != '0 && !(funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
          regWrite = 1'b0;
        end
      end
      OP_BRANCH: if (funct3 == F3_BEQ) begin
        imm = immB;
        aluOp = ALU_SUB;
        isBranch = 1'b1;
      end
      OP_JAL: begin
        imm = immJ;
        isJump = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/nextPc.sv ====
module nextPc import rvPkg::*; (
  input  word_t pc,
  input  word_t imm,
  input  logic  zero,
  input  logic  isBranch,
  input  logic  isJump,
  output word_t pcPlus4,
  output word_t pcNext
);

  word_t target;
  logic  takeTarget;

  assign pcPlus4 = pc + 32'd4;
  assign target  = pc + imm;  // imm already has bit 0 clear.

  assign takeTarget = isJump || (isBranch && zero);

  assign pcNext = takeTarget ? target : pcPlus4;

endmodule

// ==== hdl/busSequencer.sv ====
module busSequencer import rvPkg::*; #(
  parameter word_t resetVector = 32'h0
) (
  input  logic  clk,
  input  logic  rstN,
  output logic  busReq,
  output logic  busWe,
  output word_t busAddr,
  output word_t busWData,
  input  logic  busAck,
  input  word_t busRData,
  output word_t pc,
  output word_t instr,
  input  word_t aluResult,
  input  word_t rdData2,
  input  word_t pcPlus4,
  input  word_t pcNext,
  input  logic  isLoad,
  input  logic  isStore,
  input  logic  isJump,
  input  logic  regWrite,
  output logic  wrEn,
  output word_t wrData
);

  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_WAIT,
    EXEC,
    MEM_REQ,
    MEM_WAIT
  } seqState_t;

  seqState_t state;
  word_t     loadData;
  logic      ackSeen;  // req dropped and ack gone, the handshake is over.
  logic      ackCapture;

  assign ackCapture = busReq && busAck;
  assign ackSeen    = !busReq && !busAck;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state  <= FETCH_REQ;
      busReq <= 1'b0;
      busWe  <= 1'b0;
      pc     <= resetVector;
    end else begin
      case (state)
        FETCH_REQ: if (!busAck) begin
          busReq <= 1'b1;
          busWe  <= 1'b0;
          state  <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (ackCapture) begin
            busReq <= 1'b0;
          end else if (ackSeen) begin
            state <= EXEC;
          end
        end
        EXEC: begin
          if (isLoad || isStore) begin
            state <= MEM_REQ;
          end else begin
            pc    <= pcNext;
            state <= FETCH_REQ;
          end
        end
        MEM_REQ: if (!busAck) begin
          busReq <= 1'b1;
          busWe  <= isStore;
          state  <= MEM_WAIT;
        end
        MEM_WAIT: begin
          if (ackCapture) begin
            busReq <= 1'b0;
            busWe  <= 1'b0;
          end else if (ackSeen) begin
            pc    <= pcNext;  // plain pc+4 for memory instructions.
            state <= FETCH_REQ;
          end
        end
        default: state <= FETCH_REQ;
      endcase
    end
  end

  // address, data and the captured words.
  always_ff @(posedge clk) begin
    case (state)
      FETCH_REQ: if (!busAck) busAddr <= pc;
      FETCH_WAIT: if (ackCapture) instr <= busRData;
      MEM_REQ: if (!busAck) begin
        busAddr  <= aluResult;
        busWData <= rdData2;
      end
      MEM_WAIT: if (ackCapture) loadData <= busRData;
      default: ;
    endcase
  end

  // writeback lands on the same edge as the pc update.
  always_comb begin
    wrEn = 1'b0;
    if (regWrite) begin
      if (state == EXEC && !isLoad) begin
        wrEn = 1'b1;
      end else if (state == MEM_WAIT && isLoad && ackSeen) begin
        wrEn = 1'b1;
      end
    end
  end

  assign wrData = isLoad ? loadData : (isJump ? pcPlus4 : aluResult);

endmodule

// ==== hdl/rvCore.sv ====
module rvCore import rvPkg::*; #(
  parameter word_t resetVector = 32'h0
) (
  input  logic  clk,
  input  logic  rstN,
  output logic  busReq,
  output logic  busWe,
  output word_t busAddr,
  output word_t busWData,
  input  logic  busAck,
  input  word_t busRData
);

  word_t    pc, instr, imm, pcPlus4, pcNext;
  word_t    rdData1, rdData2, aluB, aluResult, wrData;
  regAddr_t rs1, rs2, rd;
  aluOp_t   aluOp;
  logic     aluSrcImm, isLoad, isStore, isBranch, isJump, regWrite;
  logic     zero, wrEn;

  busSequencer #(.resetVector(resetVector)) sequencer (
    .clk(clk), .rstN(rstN),
    .busReq(busReq), .busWe(busWe), .busAddr(busAddr), .busWData(busWData),
    .busAck(busAck), .busRData(busRData),
    .pc(pc), .instr(instr),
    .aluResult(aluResult), .rdData2(rdData2), .pcPlus4(pcPlus4), .pcNext(pcNext),
    .isLoad(isLoad), .isStore(isStore), .isJump(isJump), .regWrite(regWrite),
    .wrEn(wrEn), .wrData(wrData)
  );

  instrDecoder decoder (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
    .aluSrcImm(aluSrcImm), .isLoad(isLoad), .isStore(isStore),
    .isBranch(isBranch), .isJump(isJump), .regWrite(regWrite)
  );

  regFile regs (
    .clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wrEn(wrEn), .wrData(wrData), .rdData1(rdData1), .rdData2(rdData2)
  );

  assign aluB = aluSrcImm ? imm : rdData2;  // second operand select.

  aluUnit alu (.a(rdData1), .b(aluB), .op(aluOp), .result(aluResult), .zero(zero));

  nextPc pcSelect (
    .pc(pc), .imm(imm), .zero(zero), .isBranch(isBranch), .isJump(isJump),
    .pcPlus4(pcPlus4), .pcNext(pcNext)
  );

endmodule

// ==== sim/tbCore.sv ====
module tbCore;
  import rvPkg::*;

  localparam int NUM_INSTR    = 59;  // program words over all six runs.
  localparam int MAX_DELAY    = 3;
  localparam int RESET_CYCLES = 4 * 6;
  localparam int CYCLE_LIMIT  = NUM_INSTR * (MAX_DELAY + 8) + RESET_CYCLES;
  localparam logic [31:0] MARKER_ADDR = 32'h3fc;

  logic clk = 1'b0;
  logic rstN = 1'b0;
  logic busReq, busWe, busAck = 1'b0;
  word_t busAddr, busWData, busRData = '0;

  logic [31:0] mem [0:255];
  logic [31:0] prog [$];
  logic [31:0] readLog [$];
  logic [31:0] lcgState = 32'h8b1a;
  logic [31:0] prevAddr, prevWData;
  logic prevReq = 1'b0, prevAck = 1'b0, prevWe = 1'b0;
  logic markerHit = 1'b0, randomDelay = 1'b0;
  int curDelay = 0, waitCnt = 0, cycles = 0;

  rvCore #(.resetVector(32'h0)) uut (
    .clk(clk), .rstN(rstN), .busReq(busReq), .busWe(busWe), .busAddr(busAddr),
    .busWData(busWData), .busAck(busAck), .busRData(busRData)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // ------------------------------------------------------------
  // instruction encoders, straight from the RV32I formats
  // ------------------------------------------------------------
  function automatic logic [31:0] rOp(input logic [6:0] f7, input int rs2, input int rs1,
                                      input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input logic [31:0] imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input logic [31:0] imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] beq(input int rs1, input int rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  // ------------------------------------------------------------
  // memory responder and bus monitor
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (busReq && !busAck) begin
      if (waitCnt >= curDelay) begin
        busAck  <= 1'b1;
        waitCnt <= 0;
        if (busWe) begin
          mem[busAddr[9:2]] <= busWData;
          if (busAddr == MARKER_ADDR) markerHit <= 1'b1;
        end else begin
          busRData <= mem[busAddr[9:2]];
          readLog.push_back(busAddr);
        end
        curDelay <= randomDelay ? (nextRandom() >> 16) % (MAX_DELAY + 1) : 0;
      end else begin
        waitCnt <= waitCnt + 1;
      end
    end else if (!busReq && busAck) begin
      busAck <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (rstN) begin
      if (busReq && !prevReq && busAck) failRun("busReq was raised while busAck was still high");
      if (prevReq && !prevAck && !busReq) failRun("busReq was dropped before busAck came");
      if (busReq && !busAck && prevReq && !prevAck &&
          (busAddr !== prevAddr || busWe !== prevWe || busWData !== prevWData)) begin
        failRun("bus outputs changed while waiting for busAck");
      end
    end
    prevReq   <= busReq;
    prevAck   <= busAck;
    prevWe    <= busWe;
    prevAddr  <= busAddr;
    prevWData <= busWData;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) failRun("timeout, the program never reached the marker store");
  end

  // ------------------------------------------------------------
  // run control
  // ------------------------------------------------------------
  task automatic startRun(input logic useRandom);
    @(posedge clk);
    rstN <= 1'b0;
    randomDelay = useRandom;
    for (int i = 0; i < 256; i++) mem[i] = 32'hdead0000 ^ (i * 32'h00010101) ^ (i << 2);
    for (int i = 0; i < prog.size(); i++) mem[i] = prog[i];
  endtask

  task automatic finishRun(input logic checkStart);
    repeat (4) @(posedge clk);
    markerHit = 1'b0;
    readLog.delete();
    rstN <= 1'b1;
    @(negedge clk);
    if (checkStart) begin
      checkEq("busReq", busReq, 1'b0);  // first request comes a cycle after release.
      checkEq("busWe", busWe, 1'b0);
    end
    while (!markerHit) @(posedge clk);
  endtask

  task automatic resetTest();
    prog = '{sw(0, 0, MARKER_ADDR), jal(0, 0)};
    startRun(1'b0);
    finishRun(1'b1);
    checkEq("first busAddr", readLog[0], 32'h0);
  endtask

  task automatic aluTest(input logic useRandom);
    logic [31:0] a, b, exp [0:7];
    a = -32'sd7;
    b = 32'd12;
    exp = '{a, b, a + b, a - b, a & b, a | b, {31'b0, $signed(a) < $signed(b)},
            {31'b0, $signed(b) < $signed(a)}};
    prog = '{addi(1, 0, a), addi(2, 0, b), rOp(0, 2, 1, 0, 3), rOp(7'h20, 2, 1, 0, 4),
             rOp(0, 2, 1, 7, 5), rOp(0, 2, 1, 6, 6), rOp(0, 2, 1, 2, 7), rOp(0, 1, 2, 2, 8)};
    for (int k = 0; k < 8; k++) prog.push_back(sw(k + 1, 0, 32'h100 + 4 * k));
    prog.push_back(sw(0, 0, MARKER_ADDR));
    prog.push_back(jal(0, 0));
    startRun(useRandom);
    finishRun(1'b0);
    for (int k = 0; k < 8; k++) checkEq($sformatf("mem[%0h]", 32'h100 + 4 * k),
                                        mem[64 + k], exp[k]);
  endtask

  task automatic loadTest();
    prog = '{lw(1, 0, 32'h200), addi(2, 0, 32'h11), rOp(0, 2, 1, 0, 3),
             sw(3, 0, 32'h104), sw(0, 0, MARKER_ADDR), jal(0, 0)};
    startRun(1'b0);
    mem[32'h200 >> 2] = 32'h12345678;
    finishRun(1'b0);
    checkEq("load busAddr", readLog[1], 32'h200);
    checkEq("mem[104]", mem[32'h104 >> 2], 32'h12345678 + 32'h11);
  endtask

  task automatic branchTest();
    logic [31:0] expFetch [0:7];
    // 8 taken to 16, 16 falls through, 20 jumps to 28.
    expFetch = '{0, 4, 8, 8 + 8, 16 + 4, 20 + 8, 28 + 4, 32 + 4};
    prog = '{addi(1, 0, 5), addi(2, 0, 5), beq(1, 2, 8), addi(3, 0, 1), beq(1, 0, 8),
             jal(4, 8), addi(3, 0, 2), sw(4, 0, 32'h100), sw(3, 0, 32'h104),
             sw(0, 0, MARKER_ADDR), jal(0, 0)};
    startRun(1'b0);
    finishRun(1'b0);
    for (int k = 0; k < 8; k++) checkEq($sformatf("fetch %0d busAddr", k), readLog[k],
                                        expFetch[k]);
    checkEq("jal link", mem[32'h100 >> 2], 32'd20 + 32'd4);
    checkEq("skipped x3", mem[32'h104 >> 2], 32'h0);
  endtask

  task automatic zeroRegTest();
    prog = '{addi(0, 0, 55), sw(0, 0, 32'h100), sw(0, 0, MARKER_ADDR), jal(0, 0)};
    startRun(1'b0);
    finishRun(1'b0);
    checkEq("x0 store", mem[32'h100 >> 2], 32'h0);
  endtask

  initial begin
    resetTest();
    aluTest(1'b0);
    loadTest();
    branchTest();
    zeroRegTest();
    aluTest(1'b1);  // same program under random back-pressure.
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/rvPkg.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/instrDecoder.sv
hdl/nextPc.sv
hdl/busSequencer.sv
hdl/rvCore.sv
sim/tbCore.sv

// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - hdl/rvPkg.sv
  - hdl/aluUnit.sv
  - hdl/regFile.sv
  - hdl/instrDecoder.sv
  - hdl/nextPc.sv
  - hdl/busSequencer.sv
  - hdl/rvCore.sv
  - target: simulation
    files:
      - sim/tbCore.sv
